//--- flist.f
+incdir+include
src/tex_pkg.sv
src/tex_ram.sv
src/tex_fetch_fsm.sv
src/tex_addr_counter.sv
src/alpha_blend.sv
src/tex_unit_top.sv
test/tex_unit_props.sv
test/tex_unit_tb.sv

//--- include/tex_config.svh
`ifndef TEX_CONFIG_SVH
`define TEX_CONFIG_SVH

// Texel address width
// 17 bits gives a texel memory of 128K words
`define TEX_ADDR_W 17

// Texture number width, 64 textures
`define TEX_NUM_W 6

// Register stages inside the alpha blender
`define BLEND_STAGES 2

`endif

//--- src/alpha_blend.sv
`timescale 1ns/1ps
`include "tex_config.svh"

module alpha_blend
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input tex_pkg::rgba_t texel,
	input logic [7:0] bg_red,
	input logic [7:0] bg_green,
	input logic [7:0] bg_blue,
	output logic out_valid,
	output logic [7:0] out_red,
	output logic [7:0] out_green,
	output logic [7:0] out_blue,
	output logic [7:0] out_alpha
);

	localparam int NUM_CH = 3;

	logic [8:0] weight;
	logic [8:0] weight_inv;
	logic [7:0] fg_ch [NUM_CH];
	logic [7:0] bg_ch [NUM_CH];

	// Stage 1
	logic [15:0] fg_prod [NUM_CH];
	logic [15:0] bg_prod [NUM_CH];
	logic [7:0] alpha_s1;

	// Stage 2
	logic [15:0] blend_sum [NUM_CH];
	logic [7:0] blend_ch [NUM_CH];
	logic [7:0] alpha_s2;

	logic [`BLEND_STAGES-1:0] valid_pipe;

	// Weight runs 0..256 so that alpha 255 is fully opaque
	assign weight = {1'b0, texel.alpha} + {8'd0, texel.alpha[7]};
	assign weight_inv = 9'd256 - weight;

	// Channel order red, green, blue
	assign fg_ch[0] = texel.red;
	assign fg_ch[1] = texel.green;
	assign fg_ch[2] = texel.blue;

	assign bg_ch[0] = bg_red;
	assign bg_ch[1] = bg_green;
	assign bg_ch[2] = bg_blue;

	// Products
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_CH; i++)
		begin
			fg_prod[i] <= 16'(fg_ch[i]) * 16'(weight);
			bg_prod[i] <= 16'(bg_ch[i]) * 16'(weight_inv);
		end
		alpha_s1 <= texel.alpha;
	end

	// Sum never exceeds 255 * 256, so 16 bits hold it
	always_comb
	begin
		for (int i = 0; i < NUM_CH; i++)
		begin
			blend_sum[i] = fg_prod[i] + bg_prod[i];
		end
	end

	// Sums shifted down by 8
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_CH; i++)
		begin
			blend_ch[i] <= blend_sum[i][15:8];
		end
		alpha_s2 <= alpha_s1;
	end

	// Valid follows the data through both stages
	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			valid_pipe <= '0;
		end
		else
		begin
			valid_pipe <= {valid_pipe[`BLEND_STAGES-2:0], in_valid};
		end
	end

	assign out_valid = valid_pipe[`BLEND_STAGES-1];
	assign out_red = blend_ch[0];
	assign out_green = blend_ch[1];
	assign out_blue = blend_ch[2];
	assign out_alpha = alpha_s2;

endmodule

//--- src/tex_addr_counter.sv
`timescale 1ns/1ps

module tex_addr_counter
(
	input logic clk,
	input logic reset,
	input logic load,
	input logic step,
	input tex_pkg::tex_addr_t start_addr,
	output tex_pkg::tex_addr_t ptr
);

	import tex_pkg::*;

	tex_addr_t ptr_next;

	always_comb
	begin
		ptr_next = ptr;
		if (load)
		begin
			ptr_next = start_addr;
		end
		else if (step)
		begin
			// wraps at the top of the memory
			ptr_next = ptr + 1'b1;
		end
	end

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			ptr <= '0;
		end
		else
		begin
			ptr <= ptr_next;
		end
	end

endmodule

//--- src/tex_fetch_fsm.sv
`timescale 1ns/1ps

module tex_fetch_fsm
(
	input logic clk,
	input logic reset,
	input logic load_texture,
	input logic get_rgba,
	output logic busy,
	output logic start_re,
	output logic ptr_load,
	output logic ptr_step,
	output logic tex_re
);

	import tex_pkg::*;

	fetch_state_t state;
	fetch_state_t next_state;
	logic idle;

	assign idle = (state == IDLE);

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			state <= IDLE;
		end
		else
		begin
			state <= next_state;
		end
	end

	// Strobes only count in IDLE, load before pixel
	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				if (load_texture)
				begin
					next_state = LOAD;
				end
				else if (get_rgba)
				begin
					next_state = PIXEL;
				end
			end
			LOAD:
			begin
				next_state = IDLE;
			end
			PIXEL:
			begin
				next_state = IDLE;
			end
			default:
			begin
				next_state = IDLE;
			end
		endcase
	end

	assign busy = !idle;

	// Start table read goes out in the same cycle as the strobe
	assign start_re = idle && load_texture;

	// Table data is valid during LOAD
	assign ptr_load = (state == LOAD);

	// Read the texel at the old pointer, then advance
	assign tex_re = (state == PIXEL);
	assign ptr_step = (state == PIXEL);

endmodule

//--- src/tex_pkg.sv
`include "tex_config.svh"

package tex_pkg;

	// One texel, red in the top byte and alpha in the bottom byte
	typedef struct packed
	{
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic [7:0] alpha;
	} rgba_t;

	// Address into the texel memory
	typedef logic [`TEX_ADDR_W-1:0] tex_addr_t;

	// Index into the start table
	typedef logic [`TEX_NUM_W-1:0] tex_num_t;

	// Fetch controller states
	typedef enum logic [1:0]
	{
		IDLE,
		LOAD,
		PIXEL
	} fetch_state_t;

endpackage

//--- src/tex_ram.sv
`timescale 1ns/1ps
`include "tex_config.svh"

module tex_ram
#(
	parameter type word_t = tex_pkg::rgba_t,
	parameter int ADDR_W = `TEX_ADDR_W
)
(
	input logic clk,
	input logic we,
	input logic [ADDR_W-1:0] waddr,
	input word_t wdata,
	input logic re,
	input logic [ADDR_W-1:0] raddr,
	output word_t rdata
);

	localparam int DEPTH = 1 << ADDR_W;

	word_t mem [0:DEPTH-1];

	// Host write port
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, holds its value between reads
	always_ff @(posedge clk)
	begin
		if (re)
		begin
			rdata <= mem[raddr];
		end
	end

endmodule

//--- src/tex_unit_top.sv
`timescale 1ns/1ps
`include "tex_config.svh"

module tex_unit_top
(
	input logic clk,
	input logic reset,

	// Host writes into the texel memory
	input logic tex_we,
	input tex_pkg::tex_addr_t tex_waddr,
	input tex_pkg::rgba_t tex_wdata,

	// Host writes into the start table
	input logic start_we,
	input tex_pkg::tex_num_t start_waddr,
	input tex_pkg::tex_addr_t start_wdata,

	// Background colour, held by the host
	input logic [7:0] bg_red,
	input logic [7:0] bg_green,
	input logic [7:0] bg_blue,

	// Rasterizer strobes
	input logic load_texture,
	input logic get_rgba,
	input tex_pkg::tex_num_t tex_num,

	output logic busy,
	output logic pix_valid,
	output logic [7:0] pix_red,
	output logic [7:0] pix_green,
	output logic [7:0] pix_blue,
	output logic [7:0] pix_alpha
);

	import tex_pkg::*;

	logic start_re;
	logic tex_re;
	logic ptr_load;
	logic ptr_step;
	logic texel_valid;

	tex_addr_t start_addr;
	tex_addr_t ptr;
	rgba_t texel;

	tex_fetch_fsm fetch_fsm
	(
		.clk(clk),
		.reset(reset),
		.load_texture(load_texture),
		.get_rgba(get_rgba),
		.busy(busy),
		.start_re(start_re),
		.ptr_load(ptr_load),
		.ptr_step(ptr_step),
		.tex_re(tex_re)
	);

	// One start address per texture number
	tex_ram
	#(
		.word_t(tex_addr_t),
		.ADDR_W(`TEX_NUM_W)
	)
	start_table
	(
		.clk(clk),
		.we(start_we),
		.waddr(start_waddr),
		.wdata(start_wdata),
		.re(start_re),
		.raddr(tex_num),
		.rdata(start_addr)
	);

	tex_addr_counter addr_counter
	(
		.clk(clk),
		.reset(reset),
		.load(ptr_load),
		.step(ptr_step),
		.start_addr(start_addr),
		.ptr(ptr)
	);

	tex_ram
	#(
		.word_t(rgba_t),
		.ADDR_W(`TEX_ADDR_W)
	)
	texel_mem
	(
		.clk(clk),
		.we(tex_we),
		.waddr(tex_waddr),
		.wdata(tex_wdata),
		.re(tex_re),
		.raddr(ptr),
		.rdata(texel)
	);

	// Texel read data lands one cycle after tex_re
	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			texel_valid <= 1'b0;
		end
		else
		begin
			texel_valid <= tex_re;
		end
	end

	alpha_blend blender
	(
		.clk(clk),
		.reset(reset),
		.in_valid(texel_valid),
		.texel(texel),
		.bg_red(bg_red),
		.bg_green(bg_green),
		.bg_blue(bg_blue),
		.out_valid(pix_valid),
		.out_red(pix_red),
		.out_green(pix_green),
		.out_blue(pix_blue),
		.out_alpha(pix_alpha)
	);

endmodule

//--- test/tex_unit_props.sv
`timescale 1ns/1ps
`include "tex_config.svh"

module tex_unit_props
(
	input logic clk,
	input logic reset,
	input logic load_texture,
	input logic get_rgba,
	input logic busy,
	input logic pix_valid,
	input tex_pkg::fetch_state_t state
);

	import tex_pkg::*;

	int assert_fails = 0;

	// Accepted pixel request leaves the blender after a fixed latency
	property pixel_latency;
		@(posedge clk) disable iff (!reset)
		(state == IDLE && get_rgba && !load_texture) |-> ##(`BLEND_STAGES + 2) pix_valid;
	endproperty

	// LOAD and PIXEL each last one cycle
	property busy_one_cycle;
		@(posedge clk) disable iff (!reset)
		busy |=> !busy;
	endproperty

	property quiet_in_reset;
		@(posedge clk)
		!reset |-> !pix_valid;
	endproperty

	assert property (pixel_latency)
		else
		begin
			$error("pix_valid missing after an accepted get_rgba");
			assert_fails++;
		end
	assert property (busy_one_cycle)
		else
		begin
			$error("busy held high for two cycles in a row");
			assert_fails++;
		end
	assert property (quiet_in_reset)
		else
		begin
			$error("pix_valid high during reset");
			assert_fails++;
		end

endmodule

//--- test/tex_unit_tb.sv
`timescale 1ns/1ps
`include "tex_config.svh"

module tex_unit_tb;

	import tex_pkg::*;

	localparam int NUM_TEX = 8;
	localparam int REGION = 16;
	localparam int LATENCY = `BLEND_STAGES + 2;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic reset;
	logic tex_we;
	tex_addr_t tex_waddr;
	rgba_t tex_wdata;
	logic start_we;
	tex_num_t start_waddr;
	tex_addr_t start_wdata;
	logic [7:0] bg_red;
	logic [7:0] bg_green;
	logic [7:0] bg_blue;
	logic load_texture;
	logic get_rgba;
	tex_num_t tex_num;
	logic busy;
	logic pix_valid;
	logic [7:0] pix_red;
	logic [7:0] pix_green;
	logic [7:0] pix_blue;
	logic [7:0] pix_alpha;

	// Reference model state
	rgba_t model_mem [0:(1 << `TEX_ADDR_W)-1];
	tex_addr_t model_start [0:(1 << `TEX_NUM_W)-1];
	tex_addr_t model_ptr;
	logic [31:0] exp_pix [$];
	int exp_cyc [$];

	logic [31:0] rng_state;
	int cyc = 0;
	int errors = 0;
	int pixels_seen = 0;

	tex_unit_top dut0
	(
		.clk(clk),
		.reset(reset),
		.tex_we(tex_we),
		.tex_waddr(tex_waddr),
		.tex_wdata(tex_wdata),
		.start_we(start_we),
		.start_waddr(start_waddr),
		.start_wdata(start_wdata),
		.bg_red(bg_red),
		.bg_green(bg_green),
		.bg_blue(bg_blue),
		.load_texture(load_texture),
		.get_rgba(get_rgba),
		.tex_num(tex_num),
		.busy(busy),
		.pix_valid(pix_valid),
		.pix_red(pix_red),
		.pix_green(pix_green),
		.pix_blue(pix_blue),
		.pix_alpha(pix_alpha)
	);

	bind tex_unit_top tex_unit_props props0
	(
		.clk(clk),
		.reset(reset),
		.load_texture(load_texture),
		.get_rgba(get_rgba),
		.busy(busy),
		.pix_valid(pix_valid),
		.state(fetch_fsm.state)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cyc++;
	end

	function automatic logic [31:0] xorshift();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// Weight 0..256, alpha 255 gives the texel and alpha 0 the background
	function automatic logic [7:0] blend_channel(input int fg, input int bgc, input int alpha);
		int w;
		w = alpha + ((alpha >= 128) ? 1 : 0);
		return 8'((fg * w + bgc * (256 - w)) >> 8);
	endfunction

	function automatic logic [31:0] expected_pixel(input rgba_t t);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		r = blend_channel(t.red, bg_red, t.alpha);
		g = blend_channel(t.green, bg_green, t.alpha);
		b = blend_channel(t.blue, bg_blue, t.alpha);
		return {r, g, b, t.alpha};
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (reset && pix_valid)
		begin
			pixels_seen++;
			if (exp_pix.size() == 0)
			begin
				$display("Unexpected pixel output at %0t with no request pending", $time);
				errors++;
			end
			else
			begin
				check("pixel rgba", {pix_red, pix_green, pix_blue, pix_alpha},
					exp_pix.pop_front());
				check("pixel cycle", cyc, exp_cyc.pop_front());
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
		end
		if (busy)
		begin
			$display("Timed out at %0t waiting for busy to go low", $time);
			errors++;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_pix.size() > 0 && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
		end
		if (exp_pix.size() > 0)
		begin
			$display("Timed out at %0t with %0d pixels never delivered", $time, exp_pix.size());
			errors++;
			exp_pix.delete();
			exp_cyc.delete();
		end
	endtask

	task automatic write_texel(input tex_addr_t addr, input rgba_t data);
		tex_we = 1'b1;
		tex_waddr = addr;
		tex_wdata = data;
		model_mem[addr] = data;
		next_cycle();
		tex_we = 1'b0;
	endtask

	task automatic write_start(input tex_num_t num, input tex_addr_t addr);
		start_we = 1'b1;
		start_waddr = num;
		start_wdata = addr;
		model_start[num] = addr;
		next_cycle();
		start_we = 1'b0;
	endtask

	// Alpha mode 0 forces transparent, 1 opaque, anything else random
	task automatic fill_region(input tex_addr_t base, input int alpha_mode);
		rgba_t t;
		for (int i = 0; i < REGION; i++)
		begin
			t = rgba_t'(xorshift());
			if (alpha_mode == 0)
			begin
				t.alpha = 8'h00;
			end
			else if (alpha_mode == 1)
			begin
				t.alpha = 8'hff;
			end
			write_texel(tex_addr_t'(base + i), t);
		end
	endtask

	task automatic set_background();
		bg_red = 8'(xorshift());
		bg_green = 8'(xorshift());
		bg_blue = 8'(xorshift());
	endtask

	task automatic request_pixel();
		wait_idle();
		get_rgba = 1'b1;
		exp_pix.push_back(expected_pixel(model_mem[model_ptr]));
		exp_cyc.push_back(cyc + LATENCY);
		model_ptr++;
		next_cycle();
		get_rgba = 1'b0;
	endtask

	// With_get also raises get_rgba, which load must win over
	task automatic load_tex(input tex_num_t num, input logic with_get);
		wait_idle();
		load_texture = 1'b1;
		get_rgba = with_get;
		tex_num = num;
		model_ptr = model_start[num];
		next_cycle();
		load_texture = 1'b0;
		get_rgba = 1'b0;
	endtask

	// Pixel request followed by strobes that land while busy
	task automatic busy_strobes();
		request_pixel();
		check("busy in PIXEL", busy, 1'b1);
		load_texture = 1'b1;
		get_rgba = 1'b1;
		tex_num = tex_num_t'(xorshift() % NUM_TEX);
		next_cycle();
		load_texture = 1'b0;
		get_rgba = 1'b0;
	endtask

	task automatic idle_gap();
		int n;
		n = xorshift() % 4;
		repeat (n) next_cycle();
	endtask

	initial
	begin
		tex_num_t num;
		rng_state = 32'h401c5454;
		reset = 1'b0;
		tex_we = 1'b0;
		tex_waddr = '0;
		tex_wdata = '0;
		start_we = 1'b0;
		start_waddr = '0;
		start_wdata = '0;
		bg_red = 8'd0;
		bg_green = 8'd0;
		bg_blue = 8'd0;
		load_texture = 1'b0;
		get_rgba = 1'b0;
		tex_num = '0;
		model_ptr = '0;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b1;
		next_cycle();

		// Reset state, then a read from address 0
		check("busy after reset", busy, 1'b0);
		check("pix_valid after reset", pix_valid, 1'b0);
		set_background();
		write_texel('0, rgba_t'(xorshift()));
		request_pixel();
		wait_drain();

		// Random layout, load and step
		for (int t = 0; t < NUM_TEX; t++)
		begin
			write_start(tex_num_t'(t), tex_addr_t'(xorshift()));
			fill_region(model_start[t], 2);
		end
		for (int r = 0; r < 6; r++)
		begin
			load_tex(tex_num_t'(xorshift() % NUM_TEX), 1'b0);
			for (int k = 0; k < 6; k++)
			begin
				request_pixel();
				idle_gap();
			end
		end
		wait_drain();

		// Reload in the middle of a run
		for (int r = 0; r < 4; r++)
		begin
			load_tex(tex_num_t'(xorshift() % NUM_TEX), 1'b0);
			repeat (4) request_pixel();
			load_tex(tex_num_t'(xorshift() % NUM_TEX), 1'b0);
			repeat (8) request_pixel();
		end
		wait_drain();

		// Blend endpoints, then random alpha
		for (int m = 0; m < 3; m++)
		begin
			num = tex_num_t'(NUM_TEX + m);
			write_start(num, tex_addr_t'(xorshift()));
			fill_region(model_start[num], m);
			for (int r = 0; r < 3; r++)
			begin
				wait_drain();
				set_background();
				load_tex(num, 1'b0);
				repeat (12) request_pixel();
			end
		end
		wait_drain();

		// Strobes while busy, then load over get priority
		for (int r = 0; r < 4; r++)
		begin
			load_tex(tex_num_t'(xorshift() % NUM_TEX), 1'b0);
			busy_strobes();
			repeat (3) request_pixel();
			load_tex(tex_num_t'(xorshift() % NUM_TEX), 1'b1);
			repeat (3) request_pixel();
		end
		wait_drain();

		// Requests every two cycles
		load_tex(tex_num_t'(xorshift() % NUM_TEX), 1'b0);
		repeat (10) request_pixel();
		wait_drain();

		// Room for any stray pixel to show up
		repeat (8) next_cycle();
		$display("Pixels checked: %0d, errors: %0d, assertion failures: %0d",
			pixels_seen, errors, dut0.props0.assert_fails);
		if (errors == 0 && dut0.props0.assert_fails == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
